// File: rtl/cpuPkg.sv
// shared sizes, opcodes and instruction types for the two-stage core; imported by every rtl module
package cpuPkg;

	localparam int dataWidth = 8;                   // data path width
	localparam int regCount  = 16;                  // register file depth
	localparam int imemDepth = 64;                  // instruction words
	localparam int dmemDepth = 256;                 // data memory bytes
	localparam int ptrWidth  = $clog2(regCount);
	localparam int pcWidth   = $clog2(imemDepth);
	localparam int immWidth  = 5;                   // operand field, both views

	// fixed write targets
	localparam int ldiReg  = 1;                     // opLdi lands here
	localparam int loadReg = 2;                     // opLoad lands here
	localparam int flagReg = 4;                     // compare result, branch flag

	typedef logic [dataWidth-1:0] regWord_t;
	typedef logic [ptrWidth-1:0]  regPtr_t;
	typedef logic [pcWidth-1:0]   pcWord_t;

	typedef enum logic [3:0] {
		opAdd   = 4'b0000,
		opSub   = 4'b0001,
		opAnd   = 4'b0010,
		opXor   = 4'b0011,
		opShl   = 4'b0100,
		opLoad  = 4'b0101,
		opStore = 4'b0110,
		opLdi   = 4'b0111,
		opMovLh = 4'b1000,                          // low pointer gets high register
		opMovHl = 4'b1001,                          // high register gets low pointer
		opBeq   = 4'b1010,                          // taken when flag nonzero
		opSlt   = 4'b1011,
		opSeq   = 4'b1100,
		opBne   = 4'b1101,                          // taken when flag zero
		opHalt  = 4'b1110,
		opNop   = 4'b1111
	} opcode_t;

	typedef struct packed {
		regPtr_t ptrA;                              // full 4-bit pointer
		logic    ptrB;                              // picks r0 or r1
	} regForm_t;

	typedef struct packed {
		logic [immWidth-1:0] imm;                   // signed for branches, unsigned for opLdi
	} immForm_t;

	// same 5 bits, two decodes
	typedef union packed {
		regForm_t regForm;
		immForm_t immForm;
	} operand_u;

	typedef struct packed {
		opcode_t  op;
		operand_u operand;
	} instr_t;                                      // 9 bits

	// stage register between fetch and execute
	typedef struct packed {
		logic    valid;
		pcWord_t pc;
		instr_t  instr;
	} fetchOut_t;

endpackage

// File: rtl/fetchStage.sv
// fetch stage: program counter, instruction memory with host load port, branch redirect and flush
`timescale 1ns/1ns

module fetchStage (
	input  logic              Clk,
	input  logic              reset,
	input  bit                run,
	input  bit                halted,
	input  bit                progWe,
	input  cpuPkg::pcWord_t   progAddr,
	input  cpuPkg::instr_t    progData,
	input  bit                branchTaken,
	input  cpuPkg::pcWord_t   branchTarget,
	output cpuPkg::fetchOut_t fetchOut
);
	import cpuPkg::*;

	instr_t  imem [imemDepth];                     // program store, loaded by host
	pcWord_t pc;

	// host load port, one word per strobe
	always_ff @(posedge Clk) begin
		if (progWe)
			imem[progAddr] <= progData;
	end

	always_ff @(posedge Clk) begin
		if (reset) begin
			pc       <= '0;
			fetchOut <= '0;                          // valid low
		end else if (branchTaken) begin
			pc             <= branchTarget;          // redirect
			fetchOut.valid <= 1'b0;                  // drop the slot behind the branch
		end else if (run && !halted) begin
			fetchOut.valid <= 1'b1;
			fetchOut.pc    <= pc;
			fetchOut.instr <= imem[pc];
			pc             <= pc + 1'b1;             // wraps at imemDepth
		end else begin
			// stalled or stopped, keep pc
			fetchOut.valid <= 1'b0;                  // bubble so exec does not repeat
		end
	end

endmodule

// File: rtl/regFile.sv
// sixteen-entry register file with opcode-steered write targets and a debug read port
`timescale 1ns/1ns

module regFile (
	input  logic             Clk,
	input  logic             reset,
	input  bit               writeEn,
	input  cpuPkg::opcode_t  op,
	input  cpuPkg::regPtr_t  ptrA,
	input  bit               ptrB,
	input  cpuPkg::regWord_t dataIn,
	output cpuPkg::regWord_t dataOutA,
	output cpuPkg::regWord_t dataOutB,
	output cpuPkg::regWord_t flag,
	input  cpuPkg::regPtr_t  dbgAddr,
	output cpuPkg::regWord_t dbgData
);
	import cpuPkg::*;

	regWord_t regs [regCount];
	regPtr_t  ptrBFull;                               // 1-bit pointer widened

	assign ptrBFull = regPtr_t'(ptrB);

	// combinational reads
	assign dataOutA = regs[ptrA];
	assign dataOutB = regs[ptrBFull];                 // only r0 or r1
	assign flag     = regs[flagReg];
	assign dbgData  = regs[dbgAddr];                  // host peek after halt

	always_ff @(posedge Clk) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end else if (writeEn) begin
			case (op)
				opSlt, opSeq:
					regs[flagReg] <= dataIn;             // compare goes to flag
				opLoad:
					regs[loadReg] <= dataIn;             // load always lands in r2
				opLdi:
					regs[ldiReg] <= dataIn;
				opMovLh:
					regs[ptrBFull] <= regs[ptrA];        // high into low
				opMovHl:
					regs[ptrA] <= regs[ptrBFull];        // low into high
				default:
					regs[ptrA] <= dataIn;                // alu ops write back in place
			endcase
		end
	end

endmodule

// File: rtl/aluUnit.sv
// combinational ALU for the execute stage: arithmetic, logic, shift and compare on 8-bit operands
`timescale 1ns/1ns

module aluUnit (
	input  cpuPkg::opcode_t  op,
	input  cpuPkg::regWord_t a,
	input  cpuPkg::regWord_t b,
	output cpuPkg::regWord_t result
);
	import cpuPkg::*;

	logic [2:0] shiftAmt;
	logic       lessThan;
	logic       equal;

	assign shiftAmt = b[2:0];                        // low 3 bits only
	assign lessThan = (a < b);                       // unsigned
	assign equal    = (a == b);

	always_comb begin
		case (op)
			opAdd:
				result = a + b;
			opSub:
				result = a - b;
			opAnd:
				result = a & b;
			opXor:
				result = a ^ b;
			opShl:
				result = a << shiftAmt;
			opSlt:
				result = regWord_t'(lessThan);           // 0 or 1
			opSeq:
				result = regWord_t'(equal);
			default:
				result = b;                              // pass-through, not written back
		endcase
	end

endmodule

// File: rtl/dataMem.sv
// 256-byte data memory with combinational read and clocked write, cleared on reset
`timescale 1ns/1ns

module dataMem (
	input  logic             Clk,
	input  logic             reset,
	input  bit               writeEn,
	input  cpuPkg::regWord_t addr,
	input  cpuPkg::regWord_t writeData,
	output cpuPkg::regWord_t readData
);
	import cpuPkg::*;

	regWord_t mem [dmemDepth];

	assign readData = mem[addr];                      // async read for same-cycle load

	always_ff @(posedge Clk) begin
		if (reset) begin
			for (int i = 0; i < dmemDepth; i++)
				mem[i] <= '0;
		end else if (writeEn) begin
			mem[addr] <= writeData;
		end
	end

endmodule

// File: rtl/execStage.sv
// execute stage: decode, register read, ALU, data memory, write-back, branch resolve and HALT
`timescale 1ns/1ns

module execStage (
	input  logic              Clk,
	input  logic              reset,
	input  cpuPkg::fetchOut_t fetchOut,
	output bit                branchTaken,
	output cpuPkg::pcWord_t   branchTarget,
	output bit                halted,
	input  cpuPkg::regPtr_t   dbgAddr,
	output cpuPkg::regWord_t  dbgData
);
	import cpuPkg::*;

	opcode_t  op;
	operand_u opnd;
	logic     active;                               // valid slot and not stopped
	logic     regWe;
	logic     memWe;
	logic     isBranch;
	logic     condMet;
	regWord_t rdA;
	regWord_t rdB;
	regWord_t flag;
	regWord_t aluResult;
	regWord_t memRead;
	regWord_t immZext;
	regWord_t wbData;
	pcWord_t  branchOffset;

	assign op     = fetchOut.instr.op;
	assign opnd   = fetchOut.instr.operand;
	assign active = fetchOut.valid && !halted;       // ignore slot fetched behind HALT

	// immediate view of the operand
	assign immZext      = regWord_t'(opnd.immForm.imm);
	assign branchOffset = pcWord_t'($signed(opnd.immForm.imm));   // sign-extend to pc width

	// everything except store, branches, halt and nop writes a register
	always_comb begin
		case (op)
			opStore, opBeq, opBne, opHalt, opNop: regWe = 1'b0;
			default:                              regWe = active;
		endcase
	end

	assign memWe = active && (op == opStore);

	// write-back source
	always_comb begin
		case (op)
			opLoad:  wbData = memRead;
			opLdi:   wbData = immZext;
			default: wbData = aluResult;
		endcase
	end

	assign isBranch     = (op == opBeq) || (op == opBne);
	assign condMet      = (op == opBeq) ? (flag != '0) : (flag == '0);
	assign branchTaken  = active && isBranch && condMet;
	assign branchTarget = fetchOut.pc + branchOffset;   // relative to branch itself

	always_ff @(posedge Clk) begin
		if (reset)
			halted <= 1'b0;
		else if (active && op == opHalt)
			halted <= 1'b1;                              // sticky until reset
	end

	regFile regs (
		.Clk      (Clk),
		.reset    (reset),
		.writeEn  (regWe),
		.op       (op),
		.ptrA     (opnd.regForm.ptrA),
		.ptrB     (opnd.regForm.ptrB),
		.dataIn   (wbData),
		.dataOutA (rdA),
		.dataOutB (rdB),
		.flag     (flag),
		.dbgAddr  (dbgAddr),
		.dbgData  (dbgData)
	);

	aluUnit alu (
		.op     (op),
		.a      (rdA),
		.b      (rdB),
		.result (aluResult)
	);

	dataMem dmem (
		.Clk       (Clk),
		.reset     (reset),
		.writeEn   (memWe),
		.addr      (rdA),                             // address from ptrA register
		.writeData (rdB),
		.readData  (memRead)
	);

endmodule

// File: rtl/cpuTop.sv
// top level of the two-stage core: joins fetch and execute and exposes the host load and debug ports
`timescale 1ns/1ns

module cpuTop (
	input  logic             Clk,
	input  logic             reset,
	input  bit               run,
	input  bit               progWe,
	input  cpuPkg::pcWord_t  progAddr,
	input  cpuPkg::instr_t   progData,
	input  cpuPkg::regPtr_t  dbgAddr,
	output cpuPkg::regWord_t dbgData,
	output bit               halted
);
	import cpuPkg::*;

	fetchOut_t fetchBus;                            // stage register
	bit        branchTaken;
	pcWord_t   branchTarget;

	fetchStage fetch (
		.Clk          (Clk),
		.reset        (reset),
		.run          (run),
		.halted       (halted),
		.progWe       (progWe),
		.progAddr     (progAddr),
		.progData     (progData),
		.branchTaken  (branchTaken),
		.branchTarget (branchTarget),
		.fetchOut     (fetchBus)
	);

	execStage exec (
		.Clk          (Clk),
		.reset        (reset),
		.fetchOut     (fetchBus),
		.branchTaken  (branchTaken),
		.branchTarget (branchTarget),
		.halted       (halted),
		.dbgAddr      (dbgAddr),
		.dbgData      (dbgData)
	);

endmodule

// File: verification/cpuTb.sv
// testbench for the two-stage core: loads programs, runs them to HALT, checks registers vs a model
`timescale 1ns/1ns

module cpuTb;
	import cpuPkg::*;

	logic     Clk;
	logic     reset;
	bit       run;
	bit       progWe;
	pcWord_t  progAddr;
	instr_t   progData;
	regPtr_t  dbgAddr;
	regWord_t dbgData;
	bit       halted;

	instr_t      prog [imemDepth];                // program image, shared with the model
	int          progLen;
	regWord_t    expRegs [regCount];              // model registers
	regWord_t    expMem [dmemDepth];
	logic [31:0] lcgState;
	int          waitCycles;                      // run cycles spent waiting for halt
	int          cycleLimit;

	cpuTop uut (.*);

	always #20 Clk = ~Clk;                        // 40 ns period

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic addInstr(opcode_t op, logic [4:0] operand);
		prog[progLen] = {op, operand};
		progLen++;
	endtask

	// instruction-level model, fills expRegs and returns the count of instructions run
	function automatic int referenceRun();
		pcWord_t    pc;
		pcWord_t    nextPc;
		instr_t     ins;
		regPtr_t    pa;
		regPtr_t    pb;
		logic [4:0] imm;
		regWord_t   a;
		regWord_t   b;
		int         steps;
		for (int i = 0; i < regCount; i++)
			expRegs[i] = '0;
		for (int i = 0; i < dmemDepth; i++)
			expMem[i] = '0;
		pc    = '0;
		steps = 0;
		while (steps < 1000) begin
			ins    = prog[pc];
			pa     = ins.operand.regForm.ptrA;
			pb     = {3'b000, ins.operand.regForm.ptrB};     // r0 or r1
			imm    = ins.operand.immForm.imm;
			a      = expRegs[pa];
			b      = expRegs[pb];
			nextPc = pc + 6'd1;
			steps++;
			case (ins.op)
				opAdd:   expRegs[pa] = a + b;
				opSub:   expRegs[pa] = a - b;
				opAnd:   expRegs[pa] = a & b;
				opXor:   expRegs[pa] = a ^ b;
				opShl:   expRegs[pa] = a << b[2:0];
				opLoad:  expRegs[2] = expMem[a];
				opStore: expMem[a] = b;
				opLdi:   expRegs[1] = {3'b000, imm};
				opMovLh: expRegs[pb] = a;
				opMovHl: expRegs[pa] = b;
				opSlt:   expRegs[4] = {7'd0, a < b};
				opSeq:   expRegs[4] = {7'd0, a == b};
				opBeq:   nextPc = (expRegs[4] != 8'd0) ? pc + {imm[4], imm} : nextPc;
				opBne:   nextPc = (expRegs[4] == 8'd0) ? pc + {imm[4], imm} : nextPc;
				opHalt:  return steps;
				default: ;
			endcase
			pc = nextPc;
		end
		return steps;
	endfunction

	task automatic checkReg(regPtr_t idx, regWord_t got, regWord_t exp, string what);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s r%0d is %h, expected %h", $time, what, idx, got, exp);
			$display("TEST FAILED");
			$fatal(1, "register check failed");
		end
	endtask

	task automatic checkHalt(bit got, bit exp, string what);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s, halted is %b", $time, what, got);
			$display("TEST FAILED");
			$fatal(1, "halt check failed");
		end
	endtask

	// counts only while the core should be busy
	always @(negedge Clk) begin
		if (run && !halted) begin
			waitCycles++;
			if (waitCycles > cycleLimit) begin
				$display("timeout: halted did not rise within %0d run cycles", cycleLimit);
				$display("TEST FAILED");
				$fatal(1, "run did not finish");
			end
		end
	end

	task automatic runProgram(string name);
		int executed;
		executed   = referenceRun();
		cycleLimit = cycleLimit + 2 * executed;
		@(posedge Clk);
		reset <= 1'b1;
		run   <= 1'b0;
		repeat (5) @(posedge Clk);
		reset <= 1'b0;
		for (int i = 0; i < progLen; i++) begin     // host load, run low
			@(posedge Clk);
			progWe   <= 1'b1;
			progAddr <= pcWord_t'(i);
			progData <= prog[i];
		end
		@(posedge Clk);
		progWe <= 1'b0;
		@(negedge Clk);
		checkHalt(halted, 1'b0, {name, ": halted before run"});
		@(posedge Clk);
		run <= 1'b1;
		while (!halted)
			@(negedge Clk);
		repeat (8) @(negedge Clk);                  // keep running past HALT, nothing may move
		checkHalt(halted, 1'b1, {name, ": halted dropped while run high"});
		@(posedge Clk);
		run <= 1'b0;
		for (int i = 0; i < regCount; i++) begin    // debug port sweep
			@(posedge Clk);
			dbgAddr <= regPtr_t'(i);
			@(negedge Clk);
			checkReg(regPtr_t'(i), dbgData, expRegs[i], name);
		end
	endtask

	task automatic buildArith();
		logic [31:0] r;
		opcode_t     op;
		r       = nextRand();
		progLen = 0;
		addInstr(opLdi, r[20:16]);
		addInstr(opMovHl, {4'd0, 1'b1});                // r0 = first seed
		addInstr(opLdi, r[28:24]);                      // r1 = second seed
		for (int k = 2; k < regCount; k++)
			addInstr(opMovHl, {regPtr_t'(k), r[k]});    // spread seeds upward
		for (int k = 0; k < 16; k++) begin
			r = nextRand();
			case (r[18:16])
				3'd0, 3'd5: op = opAdd;
				3'd1:       op = opSub;
				3'd2:       op = opAnd;
				3'd3, 3'd6: op = opXor;
				3'd4:       op = opShl;
				default:    op = opMovLh;
			endcase
			addInstr(op, r[24:20]);                     // random ptrA and ptrB
		end
		addInstr(opHalt, 5'd0);
	endtask

	task automatic buildBranch();
		logic [31:0] r;
		r       = nextRand();
		progLen = 0;
		addInstr(opLdi, r[20:16]);
		addInstr(opMovHl, {4'd0, 1'b1});
		addInstr(opLdi, r[28:24]);
		addInstr(opSlt, {4'd0, 1'b1});                  // flag = r0 < r1
		addInstr(opBeq, 5'd2);                          // forward over one word
		addInstr(opMovHl, {4'd10, 1'b1});
		addInstr(opSeq, {3'b000, r[0], 1'b0});          // r0 or r1 against r0
		addInstr(opBne, 5'd2);
		addInstr(opMovHl, {4'd11, 1'b0});
		addInstr(opLdi, {2'b00, r[10:8]} + 5'd2);       // loop count 2..9
		addInstr(opMovHl, {4'd3, 1'b1});
		addInstr(opLdi, 5'd0);
		addInstr(opMovHl, {4'd0, 1'b1});                // r0 = 0 for the exit test
		addInstr(opLdi, 5'd1);                          // r1 = step
		addInstr(opSub, {4'd3, 1'b1});                  // loop top, count down
		addInstr(opAdd, {4'd6, 1'b1});                  // iteration counter
		addInstr(opSeq, {4'd3, 1'b0});
		addInstr(opBne, 5'b11101);                      // back three while count nonzero
		addInstr(opBeq, 5'd2);                          // flag is set here, always taken
		addInstr(opLdi, 5'd21);                         // behind the taken branch, must not land
		addInstr(opHalt, 5'd0);
		addInstr(opLdi, 5'd13);                         // past HALT
	endtask

	task automatic buildMemory();
		logic [31:0] r;
		progLen = 0;
		for (int k = 0; k < 4; k++) begin
			r = nextRand();
			addInstr(opLdi, {2'(k), r[18:16]});         // distinct address per k
			addInstr(opMovHl, {regPtr_t'(8 + k), 1'b1});
			addInstr(opLdi, r[28:24]);
			addInstr(opStore, {regPtr_t'(8 + k), 1'b1});
		end
		for (int k = 0; k < 4; k++) begin
			addInstr(opLoad, {regPtr_t'(8 + k), 1'b0}); // r2 = mem at r8+k
			addInstr(opMovLh, {4'd2, 1'b0});            // r0 = r2
			addInstr(opMovHl, {regPtr_t'(12 + k), 1'b0});
		end
		addInstr(opHalt, 5'd0);
	endtask

	initial begin
		Clk        = 1'b0;
		reset      = 1'b1;
		run        = 1'b0;
		progWe     = 1'b0;
		progAddr   = '0;
		progData   = '0;
		dbgAddr    = '0;
		lcgState   = 32'h95ab_a76f;
		waitCycles = 0;
		cycleLimit = 50;                            // slack on top of 2 per instruction
		progLen    = 0;
		buildArith();
		runProgram("alu");
		buildBranch();
		runProgram("branch");
		buildMemory();
		runProgram("memory");
		$display("TEST PASSED");
		$finish;
	end

endmodule

// File: cpuTop.f
rtl/cpuPkg.sv
rtl/fetchStage.sv
rtl/regFile.sv
rtl/aluUnit.sv
rtl/dataMem.sv
rtl/execStage.sv
rtl/cpuTop.sv
verification/cpuTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# builds the core and its testbench with Verilator, runs the simulation and checks the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module cpuTb -f cpuTop.f -o simCpu
./obj_dir/simCpu | tee sim.log
if grep -q "TEST PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
